//--- Makefile
# Verilator build, run and lint for the data-side MMU

VERILATOR ?= verilator
TOP       ?= tb_mmu
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TESTS PASSED" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- common/mmu_pkg.sv
// shared Sv32 types, widths and cause codes for the data-side MMU, imported by every RTL block
package mmu_pkg;

    // ------------------------------------------------------------------
    // Sv32 widths
    // ------------------------------------------------------------------
    localparam int unsigned VLEN          = 32;
    localparam int unsigned PLEN          = 34;
    localparam int unsigned PPNW          = 22;
    localparam int unsigned PAGE_OFFSET_W = 12;
    // one VPN field, Sv32 has two of them
    localparam int unsigned VPN_W         = 10;

    // privilege level as seen by loads and stores
    typedef enum logic [1:0] {
        PRIV_LVL_U = 2'b00,
        PRIV_LVL_S = 2'b01,
        PRIV_LVL_M = 2'b11
    } priv_lvl_t;

    // ------------------------------------------------------------------
    // page table entry and TLB slot
    // ------------------------------------------------------------------
    typedef struct packed {
        logic [PPNW-1:0] ppn;
        logic [1:0]      rsw;
        logic            d;
        logic            a;
        logic            g;
        logic            u;
        logic            x;
        logic            w;
        logic            r;
        logic            v;
    } pte_t;

    // is_4m marks a megapage, only vpn[19:10] takes part in the match
    typedef struct packed {
        logic                 valid;
        logic                 is_4m;
        logic [2*VPN_W-1:0]   vpn;
        logic [PPNW-1:0]      ppn;
        logic                 u;
        logic                 x;
        logic                 w;
        logic                 r;
        logic                 d;
    } tlb_entry_t;

    // fill from the walker, valid high for the single fill cycle
    typedef tlb_entry_t tlb_update_t;

    // ------------------------------------------------------------------
    // exceptions
    // ------------------------------------------------------------------
    typedef struct packed {
        logic [3:0]  cause;
        logic [31:0] tval;
        logic        valid;
    } xcpt_t;

    localparam logic [3:0] CAUSE_LD_PAGE_FAULT = 4'd13;
    localparam logic [3:0] CAUSE_ST_PAGE_FAULT = 4'd15;

    // ------------------------------------------------------------------
    // walker memory channel, credit based on the request side
    // ------------------------------------------------------------------
    typedef struct packed {
        logic            valid;
        logic [PLEN-1:0] addr;
    } mem_req_t;

    // credit may come with rdata or in a later cycle
    typedef struct packed {
        logic        valid;
        logic        credit;
        logic [31:0] rdata;
    } mem_rsp_t;

endpackage

//--- hw/mmu_data_xlate.sv
// load/store translation stage, registers the TLB result and forms the paddr and page faults
`timescale 1ns/100ps

module mmu_data_xlate (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     en_translation_i,
    input  mmu_pkg::priv_lvl_t       priv_lvl_i,
    input  logic                     sum_i,
    input  logic                     mxr_i,
    input  logic                     lsu_req_i,
    input  logic [mmu_pkg::VLEN-1:0] lsu_vaddr_i,
    input  logic                     lsu_is_store_i,
    input  logic                     tlb_hit_i,
    input  mmu_pkg::tlb_entry_t      tlb_entry_i,
    input  logic                     ptw_error_i,
    input  logic [mmu_pkg::VLEN-1:0] ptw_error_vaddr_i,
    output logic                     lsu_dtlb_hit_o,
    output logic                     lsu_valid_o,
    output logic [mmu_pkg::PLEN-1:0] lsu_paddr_o,
    output mmu_pkg::xcpt_t           lsu_exception_o
);
    import mmu_pkg::*;

    logic            req_q;
    logic            hit_q;
    logic            err_q;
    logic            is_store_q;
    logic [VLEN-1:0] vaddr_q;
    logic [VLEN-1:0] err_vaddr_q;
    tlb_entry_t      entry_q;
    logic            hit_valid;
    logic            access_err;
    logic            perm_fault;

    // bare mode is always ready
    assign lsu_dtlb_hit_o = en_translation_i ? tlb_hit_i : 1'b1;

    // result of a hit, or the end of a failed walk
    assign hit_valid   = req_q && hit_q;
    assign lsu_valid_o = hit_valid || err_q;

    // ------------------------------------------------------------------
    // physical address
    // ------------------------------------------------------------------
    always_comb begin
        lsu_paddr_o = {{(PLEN-VLEN){1'b0}}, vaddr_q};
        if (en_translation_i) begin
            lsu_paddr_o = {entry_q.ppn, vaddr_q[PAGE_OFFSET_W-1:0]};
            // megapage keeps vpn[0] from the vaddr
            if (entry_q.is_4m) begin
                lsu_paddr_o[PAGE_OFFSET_W +: VPN_W] = vaddr_q[PAGE_OFFSET_W +: VPN_W];
            end
        end
    end

    // ------------------------------------------------------------------
    // permission checks
    // ------------------------------------------------------------------
    // user page from S needs SUM, supervisor page is closed to U
    assign access_err = ((priv_lvl_i == PRIV_LVL_U) && !entry_q.u)
                     || ((priv_lvl_i == PRIV_LVL_S) && entry_q.u && !sum_i);

    // stores need w and d; MXR lets loads read execute-only pages
    assign perm_fault = is_store_q ? (!entry_q.w || !entry_q.d)
                                   : (!entry_q.r && !(entry_q.x && mxr_i));

    always_comb begin
        lsu_exception_o       = '0;
        lsu_exception_o.cause = is_store_q ? CAUSE_ST_PAGE_FAULT : CAUSE_LD_PAGE_FAULT;
        lsu_exception_o.tval  = vaddr_q;
        if (err_q) begin
            lsu_exception_o.valid = 1'b1;
            lsu_exception_o.tval  = err_vaddr_q;
        end else if (hit_valid && en_translation_i && (access_err || perm_fault)) begin
            lsu_exception_o.valid = 1'b1;
        end
    end

    // ------------------------------------------------------------------
    // request register stage
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            req_q <= 1'b0;
            hit_q <= 1'b0;
            err_q <= 1'b0;
        end else begin
            req_q <= lsu_req_i;
            hit_q <= lsu_dtlb_hit_o;
            err_q <= ptw_error_i;
        end
    end

    always_ff @(posedge clk_i) begin
        is_store_q  <= lsu_is_store_i;
        vaddr_q     <= lsu_vaddr_i;
        entry_q     <= tlb_entry_i;
        err_vaddr_q <= ptw_error_vaddr_i;
    end

endmodule

//--- hw/mmu_top.sv
// data-side Sv32 MMU top level, joins the TLB, the page table walker and the translation stage
`timescale 1ns/100ps

module mmu_top #(
    parameter int unsigned TlbEntries = 4,
    parameter int unsigned MemCredits = 2
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     en_translation_i,
    input  logic [mmu_pkg::PPNW-1:0] satp_ppn_i,
    input  mmu_pkg::priv_lvl_t       priv_lvl_i,
    input  logic                     sum_i,
    input  logic                     mxr_i,
    input  logic                     flush_tlb_i,
    input  logic                     lsu_req_i,
    input  logic [mmu_pkg::VLEN-1:0] lsu_vaddr_i,
    input  logic                     lsu_is_store_i,
    output logic                     lsu_dtlb_hit_o,
    output logic                     lsu_valid_o,
    output logic [mmu_pkg::PLEN-1:0] lsu_paddr_o,
    output mmu_pkg::xcpt_t           lsu_exception_o,
    output mmu_pkg::mem_req_t        mem_req_o,
    input  mmu_pkg::mem_rsp_t        mem_rsp_i
);
    import mmu_pkg::*;

    logic            tlb_hit;
    tlb_entry_t      tlb_entry;
    tlb_update_t     tlb_update;
    logic            ptw_miss;
    logic            ptw_error;
    logic [VLEN-1:0] ptw_error_vaddr;

    // walk only for a translated request that missed
    assign ptw_miss = lsu_req_i && en_translation_i && !tlb_hit;

    tlb #(
        .TlbEntries (TlbEntries)
    ) i_tlb (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .flush_i     (flush_tlb_i),
        .update_i    (tlb_update),
        .lu_access_i (lsu_req_i),
        .lu_vaddr_i  (lsu_vaddr_i),
        .lu_hit_o    (tlb_hit),
        .lu_entry_o  (tlb_entry)
    );

    ptw #(
        .MemCredits (MemCredits)
    ) i_ptw (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .miss_i        (ptw_miss),
        .vaddr_i       (lsu_vaddr_i),
        .satp_ppn_i    (satp_ppn_i),
        .update_o      (tlb_update),
        .error_o       (ptw_error),
        .error_vaddr_o (ptw_error_vaddr),
        .mem_req_o     (mem_req_o),
        .mem_rsp_i     (mem_rsp_i)
    );

    mmu_data_xlate i_xlate (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .en_translation_i  (en_translation_i),
        .priv_lvl_i        (priv_lvl_i),
        .sum_i             (sum_i),
        .mxr_i             (mxr_i),
        .lsu_req_i         (lsu_req_i),
        .lsu_vaddr_i       (lsu_vaddr_i),
        .lsu_is_store_i    (lsu_is_store_i),
        .tlb_hit_i         (tlb_hit),
        .tlb_entry_i       (tlb_entry),
        .ptw_error_i       (ptw_error),
        .ptw_error_vaddr_i (ptw_error_vaddr),
        .lsu_dtlb_hit_o    (lsu_dtlb_hit_o),
        .lsu_valid_o       (lsu_valid_o),
        .lsu_paddr_o       (lsu_paddr_o),
        .lsu_exception_o   (lsu_exception_o)
    );

endmodule

//--- hw/ptw/ptw.sv
// two-level Sv32 page table walker, reads PTEs over a credit-based memory port and fills the TLB
`timescale 1ns/100ps

module ptw #(
    parameter int unsigned MemCredits = 2
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     miss_i,
    input  logic [mmu_pkg::VLEN-1:0] vaddr_i,
    input  logic [mmu_pkg::PPNW-1:0] satp_ppn_i,
    output mmu_pkg::tlb_update_t     update_o,
    output logic                     error_o,
    output logic [mmu_pkg::VLEN-1:0] error_vaddr_o,
    output mmu_pkg::mem_req_t        mem_req_o,
    input  mmu_pkg::mem_rsp_t        mem_rsp_i
);
    import mmu_pkg::*;

    localparam int unsigned CntW = $clog2(MemCredits + 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_REQ,
        S_WAIT,
        S_LVL0,
        S_DONE
    } state_e;

    state_e          state_q, state_d;
    logic            lvl0_q, lvl0_d;
    logic            err_q, err_d;
    logic [CntW-1:0] credits_q, credits_d;
    logic [PLEN-1:0] addr_q, addr_d;
    logic [VLEN-1:0] vaddr_q, vaddr_d;
    logic [PPNW-1:0] next_ppn_q, next_ppn_d;
    tlb_entry_t      entry_q, entry_d;
    pte_t            pte;

    assign pte = mem_rsp_i.rdata;

    // ------------------------------------------------------------------
    // walk FSM
    // ------------------------------------------------------------------
    always_comb begin
        state_d         = state_q;
        lvl0_d          = lvl0_q;
        err_d           = err_q;
        addr_d          = addr_q;
        vaddr_d         = vaddr_q;
        next_ppn_d      = next_ppn_q;
        entry_d         = entry_q;
        mem_req_o.valid = 1'b0;
        mem_req_o.addr  = addr_q;
        case (state_q)
            S_IDLE: begin
                // level 1 PTE sits at satp.ppn * 4096 + vpn[1] * 4
                if (miss_i) begin
                    vaddr_d = vaddr_i;
                    addr_d  = {satp_ppn_i, vaddr_i[VLEN-1 -: VPN_W], 2'b00};
                    lvl0_d  = 1'b0;
                    state_d = S_REQ;
                end
            end
            S_REQ: begin
                // stall here while memory holds all credits
                if (credits_q != '0) begin
                    mem_req_o.valid = 1'b1;
                    state_d         = S_WAIT;
                end
            end
            S_WAIT: begin
                if (mem_rsp_i.valid) begin
                    state_d = S_DONE;
                    err_d   = 1'b1;
                    if (!pte.v || (pte.w && !pte.r)) begin
                        err_d = 1'b1;
                    end else if (pte.r || pte.x) begin
                        // leaf, a misaligned megapage also faults
                        if (pte.a && (lvl0_q || (pte.ppn[VPN_W-1:0] == '0))) begin
                            err_d         = 1'b0;
                            entry_d.valid = 1'b1;
                            entry_d.is_4m = !lvl0_q;
                            entry_d.vpn   = vaddr_q[VLEN-1:PAGE_OFFSET_W];
                            entry_d.ppn   = pte.ppn;
                            entry_d.u     = pte.u;
                            entry_d.x     = pte.x;
                            entry_d.w     = pte.w;
                            entry_d.r     = pte.r;
                            entry_d.d     = pte.d;
                        end
                    end else if (!lvl0_q) begin
                        // pointer to the level 0 table
                        next_ppn_d = pte.ppn;
                        state_d    = S_LVL0;
                    end
                end
            end
            S_LVL0: begin
                addr_d  = {next_ppn_q, vaddr_q[PAGE_OFFSET_W +: VPN_W], 2'b00};
                lvl0_d  = 1'b1;
                state_d = S_REQ;
            end
            S_DONE: begin
                state_d = S_IDLE;
            end
            default: begin
                state_d = S_IDLE;
            end
        endcase
    end

    // ------------------------------------------------------------------
    // credit counter
    // ------------------------------------------------------------------
    always_comb begin
        credits_d = credits_q;
        if (mem_req_o.valid) begin
            credits_d = credits_d - CntW'(1);
        end
        if (mem_rsp_i.credit) begin
            credits_d = credits_d + CntW'(1);
        end
    end

    // one-cycle fill or error pulse from the done state
    always_comb begin
        update_o       = entry_q;
        update_o.valid = (state_q == S_DONE) && !err_q;
    end
    assign error_o       = (state_q == S_DONE) && err_q;
    assign error_vaddr_o = vaddr_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q   <= S_IDLE;
            lvl0_q    <= 1'b0;
            err_q     <= 1'b0;
            credits_q <= CntW'(MemCredits);
        end else begin
            state_q   <= state_d;
            lvl0_q    <= lvl0_d;
            err_q     <= err_d;
            credits_q <= credits_d;
        end
    end

    always_ff @(posedge clk_i) begin
        addr_q     <= addr_d;
        vaddr_q    <= vaddr_d;
        next_ppn_q <= next_ppn_d;
        entry_q    <= entry_d;
    end

endmodule

//--- hw/tlb/tlb.sv
// fully associative data TLB that the page table walker fills and the load/store port looks up
`timescale 1ns/100ps

module tlb #(
    parameter int unsigned TlbEntries = 4
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    input  mmu_pkg::tlb_update_t     update_i,
    input  logic                     lu_access_i,
    input  logic [mmu_pkg::VLEN-1:0] lu_vaddr_i,
    output logic                     lu_hit_o,
    output mmu_pkg::tlb_entry_t      lu_entry_o
);
    import mmu_pkg::*;

    // keep the pointer at least one bit wide for a single entry
    localparam int unsigned IdxW = (TlbEntries > 1) ? $clog2(TlbEntries) : 1;

    logic [TlbEntries-1:0] valid_q;
    tlb_entry_t            entries_q [TlbEntries];
    logic [IdxW-1:0]       fill_ptr_q;
    logic [TlbEntries-1:0] match;
    logic [VPN_W-1:0]      lu_vpn1;
    logic [VPN_W-1:0]      lu_vpn0;

    assign lu_vpn1 = lu_vaddr_i[VLEN-1 -: VPN_W];
    assign lu_vpn0 = lu_vaddr_i[PAGE_OFFSET_W +: VPN_W];

    // ------------------------------------------------------------------
    // lookup
    // ------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < TlbEntries; i++) begin
            // megapage ignores vpn[0]
            match[i] = valid_q[i]
                    && (entries_q[i].vpn[2*VPN_W-1:VPN_W] == lu_vpn1)
                    && (entries_q[i].is_4m || (entries_q[i].vpn[VPN_W-1:0] == lu_vpn0));
        end
    end

    always_comb begin
        lu_hit_o   = 1'b0;
        lu_entry_o = '0;
        for (int i = 0; i < TlbEntries; i++) begin
            if (lu_access_i && match[i]) begin
                lu_hit_o         = 1'b1;
                lu_entry_o       = entries_q[i];
                lu_entry_o.valid = 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------
    // fill and flush
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q    <= '0;
            fill_ptr_q <= '0;
        end else if (flush_i) begin
            // flush wins over a fill in the same cycle
            valid_q <= '0;
        end else if (update_i.valid) begin
            valid_q[fill_ptr_q] <= 1'b1;
            // round robin pointer wraps at the last slot
            if (fill_ptr_q == IdxW'(TlbEntries - 1)) begin
                fill_ptr_q <= '0;
            end else begin
                fill_ptr_q <= fill_ptr_q + IdxW'(1);
            end
        end
    end

    // slot contents written by a walker fill
    always_ff @(posedge clk_i) begin
        if (update_i.valid && !flush_i) begin
            entries_q[fill_ptr_q] <= update_i;
        end
    end

endmodule

//--- src.f
common/mmu_pkg.sv
hw/tlb/tlb.sv
hw/ptw/ptw.sv
hw/mmu_data_xlate.sv
hw/mmu_top.sv
tb/mmu_chk.sv
tb/tb_mmu.sv

//--- tb/mmu_chk.sv
// assertion checker bound to the page table walker to watch its credit channel and reset state
`timescale 1ns/100ps

module mmu_chk #(
    parameter int unsigned MemCredits = 2
) (
    input logic                                clk_i,
    input logic                                rst_ni,
    input logic                                req_valid_i,
    input logic                                rsp_valid_i,
    input logic [$clog2(MemCredits+1)-1:0]     credits_i,
    input logic                                fill_i,
    input logic                                error_i
);

    // ------------------------------------------------------------------
    // credit protocol
    // ------------------------------------------------------------------
    // a request may only leave while a credit is left
    credit_spent: assert property (@(posedge clk_i) disable iff (!rst_ni)
        req_valid_i |-> (credits_i != '0))
        else $error("memory request issued with no credit left");

    // returned credits never exceed what memory was given
    credit_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
        credits_i <= MemCredits)
        else $error("credit counter above its reset value");

    // a walk only ends in the cycle after a PTE came back
    walk_end_after_rsp: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (fill_i || error_i) |-> $past(rsp_valid_i))
        else $error("walk ended without a memory response");

    // idle walker with full credits while reset is held
    reset_state: assert property (@(posedge clk_i)
        !rst_ni |-> (!req_valid_i && (credits_i == MemCredits) && !fill_i && !error_i))
        else $error("walker not in its reset state during reset");

endmodule

//--- tb/tb_mmu.sv
// directed testbench that drives the data-side MMU top level against a page-table memory model
`timescale 1ns/100ps

module tb_mmu;
    import mmu_pkg::*;

    localparam int unsigned     TIMEOUT  = 200;
    localparam logic [31:0]     SEED     = 32'hd6b0_3563;
    localparam logic [PPNW-1:0] ROOT_PPN = 22'h00100;
    localparam logic [PPNW-1:0] L0_PPN   = 22'h00101;
    localparam xcpt_t           NO_XCPT  = '0;

    // PTE flag bits in Sv32 order
    localparam logic [7:0] F_V = 8'h01;
    localparam logic [7:0] F_R = 8'h02;
    localparam logic [7:0] F_W = 8'h04;
    localparam logic [7:0] F_U = 8'h10;
    localparam logic [7:0] F_A = 8'h40;
    localparam logic [7:0] F_D = 8'h80;

    logic            clk_i = 1'b0;
    logic            rst_ni;
    logic            en_translation_i;
    logic [PPNW-1:0] satp_ppn_i;
    priv_lvl_t       priv_lvl_i;
    logic            sum_i;
    logic            mxr_i;
    logic            flush_tlb_i;
    logic            lsu_req_i;
    logic [VLEN-1:0] lsu_vaddr_i;
    logic            lsu_is_store_i;
    logic            lsu_dtlb_hit_o;
    logic            lsu_valid_o;
    logic [PLEN-1:0] lsu_paddr_o;
    xcpt_t           lsu_exception_o;
    mem_req_t        mem_req_o;
    mem_rsp_t        mem_rsp_i = '0;

    // page tables keyed by physical byte address where absent words read as zero
    logic [31:0]     pt_mem [logic [PLEN-1:0]];
    int unsigned     req_count = 0;
    int unsigned     rsp_delay = 0;
    logic [PLEN-1:0] rsp_addr;
    int unsigned     errors;
    int unsigned     timeouts;

    // what the last access saw
    logic            hit_seen;
    int unsigned     latency;
    int unsigned     walk_reads;
    logic [PLEN-1:0] paddr_seen;
    xcpt_t           xcpt_seen;

    always #10 clk_i = ~clk_i;

    mmu_top #(
        .TlbEntries (4),
        .MemCredits (2)
    ) i_dut (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .en_translation_i (en_translation_i),
        .satp_ppn_i       (satp_ppn_i),
        .priv_lvl_i       (priv_lvl_i),
        .sum_i            (sum_i),
        .mxr_i            (mxr_i),
        .flush_tlb_i      (flush_tlb_i),
        .lsu_req_i        (lsu_req_i),
        .lsu_vaddr_i      (lsu_vaddr_i),
        .lsu_is_store_i   (lsu_is_store_i),
        .lsu_dtlb_hit_o   (lsu_dtlb_hit_o),
        .lsu_valid_o      (lsu_valid_o),
        .lsu_paddr_o      (lsu_paddr_o),
        .lsu_exception_o  (lsu_exception_o),
        .mem_req_o        (mem_req_o),
        .mem_rsp_i        (mem_rsp_i)
    );

    // protocol checker on every walker
    bind ptw mmu_chk #(
        .MemCredits (MemCredits)
    ) i_mmu_chk (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .req_valid_i (mem_req_o.valid),
        .rsp_valid_i (mem_rsp_i.valid),
        .credits_i   (credits_q),
        .fill_i      (update_o.valid),
        .error_i     (error_o)
    );

    // ------------------------------------------------------------------
    // page table memory model
    // ------------------------------------------------------------------
    function automatic logic [31:0] read_word(input logic [PLEN-1:0] addr);
        return pt_mem.exists(addr) ? pt_mem[addr] : 32'h0;
    endfunction

    // one read at a time answered after 1 to 4 cycles together with its credit
    always @(negedge clk_i) begin : mem_model
        mem_rsp_t rsp;
        rsp = '0;
        if (rsp_delay != 0) begin
            rsp_delay = rsp_delay - 1;
            if (rsp_delay == 0) begin
                rsp.valid  = 1'b1;
                rsp.credit = 1'b1;
                rsp.rdata  = read_word(rsp_addr);
            end
        end
        if (rst_ni && mem_req_o.valid) begin
            req_count = req_count + 1;
            rsp_addr  = mem_req_o.addr;
            rsp_delay = $urandom_range(4, 1);
        end
        mem_rsp_i = rsp;
    end

    function automatic pte_t make_pte(input logic [PPNW-1:0] ppn, input logic [7:0] flags);
        pte_t p;
        p     = '0;
        p.ppn = ppn;
        {p.d, p.a, p.g, p.u, p.x, p.w, p.r, p.v} = flags;
        return p;
    endfunction

    // table base is ppn * 4096 and each PTE is four bytes
    task automatic set_pte(input logic [PPNW-1:0] tbl, input logic [VPN_W-1:0] idx,
                           input pte_t p);
        pt_mem[{tbl, idx, 2'b00}] = p;
    endtask

    function automatic xcpt_t page_fault(input logic [VLEN-1:0] va, input logic store);
        xcpt_t x;
        x.cause = store ? CAUSE_ST_PAGE_FAULT : CAUSE_LD_PAGE_FAULT;
        x.tval  = va;
        x.valid = 1'b1;
        return x;
    endfunction

    // ------------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------------
    task automatic check_paddr(input logic [PLEN-1:0] got, input logic [PLEN-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("** Error: lsu_paddr_o got 0x%h, expected 0x%h", got, exp);
        end
    endtask

    // cause and tval only matter for a raised exception
    task automatic check_xcpt(input xcpt_t got, input xcpt_t exp);
        if (got.valid !== exp.valid
                || (exp.valid && (got.cause !== exp.cause || got.tval !== exp.tval))) begin
            errors++;
            $display("** Error: lsu_exception_o got valid 0x%h cause 0x%h tval 0x%h, %s",
                     got.valid, got.cause, got.tval, "expected");
            $display("         valid 0x%h cause 0x%h tval 0x%h", exp.valid, exp.cause, exp.tval);
        end
    endtask

    task automatic check_hit(input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("** Error: lsu_dtlb_hit_o got 0x%h, expected 0x%h", got, exp);
        end
    endtask

    task automatic expect_count(input string what, input int unsigned got,
                                input int unsigned exp);
        if (got != exp) begin
            errors++;
            $display("%s was %0d, expected %0d", what, got, exp);
        end
    endtask

    // ------------------------------------------------------------------
    // access driver
    // ------------------------------------------------------------------
    // holds the request until lsu_valid_o and samples the hit in the request cycle
    task automatic access(input logic en, input logic [VLEN-1:0] va, input logic store,
                          input priv_lvl_t priv, input logic sum);
        int unsigned reads_before;
        @(negedge clk_i);
        en_translation_i = en;
        priv_lvl_i       = priv;
        sum_i            = sum;
        lsu_req_i        = 1'b1;
        lsu_vaddr_i      = va;
        lsu_is_store_i   = store;
        #1;
        hit_seen     = lsu_dtlb_hit_o;
        reads_before = req_count;
        latency      = 0;
        // no result may show up in the request cycle itself
        if (lsu_valid_o !== 1'b0) begin
            errors++;
            $display("** Error: lsu_valid_o got 0x%h in the request cycle, expected 0x0",
                     lsu_valid_o);
        end
        do begin
            @(negedge clk_i);
            latency++;
        end while (!lsu_valid_o && latency < TIMEOUT);
        paddr_seen = lsu_paddr_o;
        xcpt_seen  = lsu_exception_o;
        if (!lsu_valid_o) begin
            timeouts++;
            $display("no lsu_valid_o within %0d cycles for vaddr 0x%h", TIMEOUT, va);
        end
        lsu_req_i = 1'b0;
        #1;
        walk_reads = req_count - reads_before;
    endtask

    task automatic flush_tlb();
        @(negedge clk_i);
        flush_tlb_i = 1'b1;
        @(negedge clk_i);
        flush_tlb_i = 1'b0;
    endtask

    // ------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------
    task automatic bare_mode_passthrough();
        logic [VLEN-1:0] va;
        logic            st;
        for (int i = 0; i < 8; i++) begin
            va = $urandom();
            st = 1'($urandom_range(1, 0));
            access(1'b0, va, st, PRIV_LVL_S, 1'b0);
            check_hit(hit_seen, 1'b1);
            expect_count("bare mode latency", latency, 1);
            expect_count("bare mode memory reads", walk_reads, 0);
            check_paddr(paddr_seen, {2'b00, va});
            check_xcpt(xcpt_seen, NO_XCPT);
        end
    endtask

    task automatic small_page_walk();
        pte_t            leaf;
        logic [VLEN-1:0] va;
        leaf = make_pte(22'h2_3456, F_V | F_R | F_W | F_A | F_D);
        set_pte(L0_PPN, 10'd1, leaf);
        va = 32'h0040_1abc;
        access(1'b1, va, 1'b0, PRIV_LVL_S, 1'b0);
        check_hit(hit_seen, 1'b0);
        expect_count("walk reads for a 4 KiB page", walk_reads, 2);
        check_paddr(paddr_seen, {leaf.ppn, va[11:0]});
        check_xcpt(xcpt_seen, NO_XCPT);
        // same page again hits with one cycle of latency
        va = 32'h0040_1004;
        access(1'b1, va, 1'b1, PRIV_LVL_S, 1'b0);
        check_hit(hit_seen, 1'b1);
        expect_count("hit latency", latency, 1);
        expect_count("walk reads on a hit", walk_reads, 0);
        check_paddr(paddr_seen, {leaf.ppn, va[11:0]});
        check_xcpt(xcpt_seen, NO_XCPT);
    endtask

    task automatic megapage_walk();
        pte_t            leaf;
        logic [VLEN-1:0] va;
        va   = 32'h0c8a_5123;
        leaf = make_pte({12'h3c7, 10'h000}, F_V | F_R | F_W | F_A | F_D);
        set_pte(ROOT_PPN, va[31:22], leaf);
        access(1'b1, va, 1'b0, PRIV_LVL_S, 1'b0);
        expect_count("walk reads for a megapage", walk_reads, 1);
        check_paddr(paddr_seen, {leaf.ppn[21:10], va[21:12], va[11:0]});
        check_xcpt(xcpt_seen, NO_XCPT);
    endtask

    task automatic permission_faults();
        logic [VLEN-1:0] va;
        pte_t            leaf;
        set_pte(L0_PPN, 10'd2, make_pte(22'h0_0a02, F_V | F_R | F_A | F_D));
        set_pte(L0_PPN, 10'd3, make_pte(22'h0_0a03, F_V | F_R | F_W | F_A));
        leaf = make_pte(22'h0_0a04, F_V | F_R | F_W | F_A | F_D | F_U);
        set_pte(L0_PPN, 10'd4, leaf);
        set_pte(L0_PPN, 10'd5, make_pte(22'h0_0a05, F_V | F_R | F_W | F_A | F_D));
        // store without w and then store without d
        va = {10'd1, 10'd2, 12'h010};
        access(1'b1, va, 1'b1, PRIV_LVL_S, 1'b0);
        check_xcpt(xcpt_seen, page_fault(va, 1'b1));
        va = {10'd1, 10'd3, 12'h020};
        access(1'b1, va, 1'b1, PRIV_LVL_S, 1'b0);
        check_xcpt(xcpt_seen, page_fault(va, 1'b1));
        // user page from S mode faults until SUM is set
        va = {10'd1, 10'd4, 12'h030};
        access(1'b1, va, 1'b0, PRIV_LVL_S, 1'b0);
        check_xcpt(xcpt_seen, page_fault(va, 1'b0));
        access(1'b1, va, 1'b0, PRIV_LVL_S, 1'b1);
        check_hit(hit_seen, 1'b1);
        check_paddr(paddr_seen, {leaf.ppn, va[11:0]});
        check_xcpt(xcpt_seen, NO_XCPT);
        // supervisor page from U mode
        va = {10'd1, 10'd5, 12'h040};
        access(1'b1, va, 1'b0, PRIV_LVL_U, 1'b0);
        check_xcpt(xcpt_seen, page_fault(va, 1'b0));
    endtask

    task automatic walk_fault_and_flush();
        logic [VLEN-1:0] va;
        pte_t            leaf;
        // invalid level 0 PTE
        set_pte(L0_PPN, 10'd6, '0);
        va = {10'd1, 10'd6, 12'h050};
        access(1'b1, va, 1'b0, PRIV_LVL_S, 1'b0);
        expect_count("walk reads before the fault", walk_reads, 2);
        check_xcpt(xcpt_seen, page_fault(va, 1'b0));
        // user page from the permission test is still cached
        leaf = make_pte(22'h0_0a04, F_V | F_R | F_W | F_A | F_D | F_U);
        va   = {10'd1, 10'd4, 12'h060};
        access(1'b1, va, 1'b0, PRIV_LVL_S, 1'b1);
        check_hit(hit_seen, 1'b1);
        flush_tlb();
        access(1'b1, va, 1'b0, PRIV_LVL_S, 1'b1);
        check_hit(hit_seen, 1'b0);
        expect_count("walk reads after flush", walk_reads, 2);
        check_paddr(paddr_seen, {leaf.ppn, va[11:0]});
        check_xcpt(xcpt_seen, NO_XCPT);
    endtask

    // ------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------
    initial begin
        void'($urandom(SEED));
        rst_ni           = 1'b1;
        en_translation_i = 1'b0;
        satp_ppn_i       = ROOT_PPN;
        priv_lvl_i       = PRIV_LVL_S;
        sum_i            = 1'b0;
        mxr_i            = 1'b0;
        flush_tlb_i      = 1'b0;
        lsu_req_i        = 1'b0;
        lsu_vaddr_i      = '0;
        lsu_is_store_i   = 1'b0;
        errors           = 0;
        timeouts         = 0;
        // root entry 1 points at the shared level 0 table
        set_pte(ROOT_PPN, 10'd1, make_pte(L0_PPN, F_V));
        #1 rst_ni = 1'b0;
        repeat (10) @(negedge clk_i);
        rst_ni = 1'b1;

        bare_mode_passthrough();
        small_page_walk();
        megapage_walk();
        permission_faults();
        walk_fault_and_flush();

        $display("value errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
